// ==== include/echo_defs.svh ====
`ifndef ECHO_DEFS_SVH
`define ECHO_DEFS_SVH

// Beat data width of the MAC-facing streams
`define MAC_INTERFACE_W 32

// Count of unused bytes in an end beat
`define MAC_PADBYTES_W 2

// Frame byte size wide enough for one MTU
`define MTU_SIZE_W 11

// Data FIFO holds 32 beats
`define PKT_QUEUE_LOG_ELS 5

// Size FIFO holds 8 frames
`define SIZE_QUEUE_LOG_ELS 3

`endif

// ==== src/frame_pkg.sv ====
`default_nettype none

`include "echo_defs.svh"

package frame_pkg;

    // Bytes carried by one full beat
    localparam int BEAT_BYTES = `MAC_INTERFACE_W / 8;

    // One beat of a flagged frame stream
    typedef struct packed {
        logic [`MAC_INTERFACE_W-1:0] data;
        logic                        startframe;
        logic                        endframe;
        logic [`MAC_PADBYTES_W-1:0]  padbytes;
    } frame_beat_t;

    // Byte size of a whole frame
    typedef logic [`MTU_SIZE_W-1:0] frame_size_t;

endpackage

`default_nettype wire

// ==== src/echo_pkg.sv ====
`default_nettype none

`include "echo_defs.svh"

package echo_pkg;

    // Port pair carried in the first word of a frame
    typedef struct packed {
        logic [`MAC_INTERFACE_W/2-1:0] dst_port;
        logic [`MAC_INTERFACE_W/2-1:0] src_port;
    } port_pair_t;

    // First beat seen either as a raw word or as two ports
    typedef union packed {
        logic [`MAC_INTERFACE_W-1:0] raw;
        port_pair_t                  ports;
    } port_hdr_u;

endpackage

`default_nettype wire

// ==== src/frame_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface frame_stream_if;

    logic                   val;
    frame_pkg::frame_beat_t beat;
    // Only meaningful on a start beat
    frame_pkg::frame_size_t frame_size;
    logic                   rdy;

    modport src (
        output val,
        output beat,
        output frame_size,
        input  rdy
    );

    modport dst (
        input  val,
        input  beat,
        input  frame_size,
        output rdy
    );

endinterface

`default_nettype wire

// ==== src/startframe_convert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module startframe_convert (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire logic                        src_val_i,
    input  wire logic [`MAC_INTERFACE_W-1:0] src_data_i,
    input  wire logic                        src_last_i,
    input  wire logic [`MAC_PADBYTES_W-1:0]  src_padbytes_i,
    output logic                             src_rdy_o,

    frame_stream_if.src                      dst
);

    logic in_frame_r;
    logic src_xfer;

    assign src_xfer = src_val_i & src_rdy_o;

    // Pure pass-through apart from the start flag
    assign dst.val             = src_val_i;
    assign dst.beat.data       = src_data_i;
    assign dst.beat.startframe = ~in_frame_r;
    assign dst.beat.endframe   = src_last_i;
    assign dst.beat.padbytes   = src_padbytes_i;
    assign dst.frame_size      = '0;
    assign src_rdy_o           = dst.rdy;

    // Next beat starts a frame after reset and after every last beat
    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame_r <= 1'b0;
        end else if (src_xfer) begin
            in_frame_r <= ~src_last_i;
        end
    end

    a_pad_only_on_last: assert property (
        @(posedge clk) disable iff (rst)
        (src_xfer && !src_last_i) |-> (src_padbytes_i == '0)
    );

endmodule

`default_nettype wire

// ==== src/packet_queue_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module packet_queue_controller (
    input  wire logic   clk,
    input  wire logic   rst,

    frame_stream_if.dst wr,
    frame_stream_if.src rd
);

    localparam int DATA_ELS = 2 ** `PKT_QUEUE_LOG_ELS;
    localparam int SIZE_ELS = 2 ** `SIZE_QUEUE_LOG_ELS;

    frame_pkg::frame_beat_t data_mem [DATA_ELS];
    frame_pkg::frame_size_t size_mem [SIZE_ELS];

    // Pointers carry one extra wrap bit
    logic [`PKT_QUEUE_LOG_ELS:0]  data_wr_ptr;
    logic [`PKT_QUEUE_LOG_ELS:0]  data_rd_ptr;
    logic [`SIZE_QUEUE_LOG_ELS:0] size_wr_ptr;
    logic [`SIZE_QUEUE_LOG_ELS:0] size_rd_ptr;

    logic data_full;
    logic data_empty;
    logic size_full;
    logic size_empty;

    logic wr_xfer;
    logic rd_xfer;
    logic size_push;
    logic size_pop;

    frame_pkg::frame_size_t byte_cnt_r;
    frame_pkg::frame_size_t frame_bytes;
    frame_pkg::frame_size_t frame_total;
    frame_pkg::frame_beat_t head_beat;

    assign data_empty = (data_wr_ptr == data_rd_ptr);
    assign data_full  = (data_wr_ptr[`PKT_QUEUE_LOG_ELS] != data_rd_ptr[`PKT_QUEUE_LOG_ELS])
                     && (data_wr_ptr[`PKT_QUEUE_LOG_ELS-1:0]
                         == data_rd_ptr[`PKT_QUEUE_LOG_ELS-1:0]);

    assign size_empty = (size_wr_ptr == size_rd_ptr);
    assign size_full  = (size_wr_ptr[`SIZE_QUEUE_LOG_ELS] != size_rd_ptr[`SIZE_QUEUE_LOG_ELS])
                     && (size_wr_ptr[`SIZE_QUEUE_LOG_ELS-1:0]
                         == size_rd_ptr[`SIZE_QUEUE_LOG_ELS-1:0]);

    // A new frame may only begin once there is room for its size
    assign wr.rdy  = ~data_full & ~(size_full & wr.beat.startframe);
    assign wr_xfer = wr.val & wr.rdy;

    // Byte count restarts on every start beat
    assign frame_bytes = (wr.beat.startframe ? '0 : byte_cnt_r)
                       + frame_pkg::frame_size_t'(frame_pkg::BEAT_BYTES);
    assign frame_total = frame_bytes - frame_pkg::frame_size_t'(wr.beat.padbytes);
    assign size_push   = wr_xfer & wr.beat.endframe;

    always_ff @(posedge clk) begin
        if (rst) begin
            byte_cnt_r <= '0;
        end else if (wr_xfer) begin
            byte_cnt_r <= frame_bytes;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_xfer) begin
            data_mem[data_wr_ptr[`PKT_QUEUE_LOG_ELS-1:0]] <= wr.beat;
        end
        if (size_push) begin
            size_mem[size_wr_ptr[`SIZE_QUEUE_LOG_ELS-1:0]] <= frame_total;
        end
    end

    // A start beat waits on the read side until its frame is fully stored
    assign head_beat = data_mem[data_rd_ptr[`PKT_QUEUE_LOG_ELS-1:0]];

    assign rd.val        = ~data_empty & (~head_beat.startframe | ~size_empty);
    assign rd.beat       = head_beat;
    assign rd.frame_size = head_beat.startframe
                         ? size_mem[size_rd_ptr[`SIZE_QUEUE_LOG_ELS-1:0]] : '0;

    assign rd_xfer  = rd.val & rd.rdy;
    assign size_pop = rd_xfer & head_beat.startframe;

    always_ff @(posedge clk) begin
        if (rst) begin
            data_wr_ptr <= '0;
            data_rd_ptr <= '0;
            size_wr_ptr <= '0;
            size_rd_ptr <= '0;
        end else begin
            if (wr_xfer) begin
                data_wr_ptr <= data_wr_ptr + 1'b1;
            end
            if (rd_xfer) begin
                data_rd_ptr <= data_rd_ptr + 1'b1;
            end
            if (size_push) begin
                size_wr_ptr <= size_wr_ptr + 1'b1;
            end
            if (size_pop) begin
                size_rd_ptr <= size_rd_ptr + 1'b1;
            end
        end
    end

    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        wr_xfer |-> !data_full
    );

    a_no_size_pop_when_empty: assert property (
        @(posedge clk) disable iff (rst)
        size_pop |-> !size_empty
    );

endmodule

`default_nettype wire

// ==== src/echo_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module echo_engine (
    input  wire logic                        clk,
    input  wire logic                        rst,

    frame_stream_if.dst                      rx,

    output logic                             tx_val_o,
    output logic [`MAC_INTERFACE_W-1:0]      tx_data_o,
    output logic                             tx_startframe_o,
    output logic                             tx_endframe_o,
    output logic [`MAC_PADBYTES_W-1:0]       tx_padbytes_o,
    output logic [`MTU_SIZE_W-1:0]           tx_frame_size_o,
    input  wire logic                        tx_rdy_i
);

    logic                   stage_val_r;
    frame_pkg::frame_beat_t stage_beat_r;
    frame_pkg::frame_size_t stage_size_r;

    echo_pkg::port_hdr_u    hdr_in;
    echo_pkg::port_hdr_u    hdr_swapped;
    frame_pkg::frame_beat_t next_beat;
    logic                   rx_xfer;

    // Stage accepts when empty or when it drains this cycle
    assign rx.rdy  = ~stage_val_r | tx_rdy_i;
    assign rx_xfer = rx.val & rx.rdy;

    // First word of a frame holds the two ports
    assign hdr_in.raw                 = rx.beat.data;
    assign hdr_swapped.ports.dst_port = hdr_in.ports.src_port;
    assign hdr_swapped.ports.src_port = hdr_in.ports.dst_port;

    always_comb begin
        next_beat = rx.beat;
        if (rx.beat.startframe) begin
            next_beat.data = hdr_swapped.raw;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_val_r <= 1'b0;
        end else if (rx.rdy) begin
            stage_val_r <= rx.val;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_xfer) begin
            stage_beat_r <= next_beat;
            stage_size_r <= rx.frame_size;
        end
    end

    assign tx_val_o        = stage_val_r;
    assign tx_data_o       = stage_beat_r.data;
    assign tx_startframe_o = stage_beat_r.startframe;
    assign tx_endframe_o   = stage_beat_r.endframe;
    assign tx_padbytes_o   = stage_beat_r.padbytes;
    assign tx_frame_size_o = stage_size_r;

    // A stalled beat must not change under the receiver
    a_tx_hold_when_stalled: assert property (
        @(posedge clk) disable iff (rst)
        (tx_val_o && !tx_rdy_i) |=>
            (tx_val_o && $stable(tx_data_o) && $stable(tx_startframe_o)
             && $stable(tx_endframe_o) && $stable(tx_padbytes_o)
             && $stable(tx_frame_size_o))
    );

endmodule

`default_nettype wire

// ==== src/echo_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module echo_top (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire logic                        rx_val_i,
    input  wire logic [`MAC_INTERFACE_W-1:0] rx_data_i,
    input  wire logic                        rx_last_i,
    input  wire logic [`MAC_PADBYTES_W-1:0]  rx_padbytes_i,
    output logic                             rx_rdy_o,

    output logic                             tx_val_o,
    output logic [`MAC_INTERFACE_W-1:0]      tx_data_o,
    output logic                             tx_startframe_o,
    output logic                             tx_endframe_o,
    output logic [`MAC_PADBYTES_W-1:0]       tx_padbytes_o,
    output logic [`MTU_SIZE_W-1:0]           tx_frame_size_o,
    input  wire logic                        tx_rdy_i
);

    frame_stream_if conv_q ();
    frame_stream_if q_eng ();

    startframe_convert u_convert (
        .clk            (clk),
        .rst            (rst),
        .src_val_i      (rx_val_i),
        .src_data_i     (rx_data_i),
        .src_last_i     (rx_last_i),
        .src_padbytes_i (rx_padbytes_i),
        .src_rdy_o      (rx_rdy_o),
        .dst            (conv_q.src)
    );

    // Frames are released only once fully stored
    packet_queue_controller u_pkt_queue (
        .clk (clk),
        .rst (rst),
        .wr  (conv_q.dst),
        .rd  (q_eng.src)
    );

    echo_engine u_echo (
        .clk             (clk),
        .rst             (rst),
        .rx              (q_eng.dst),
        .tx_val_o        (tx_val_o),
        .tx_data_o       (tx_data_o),
        .tx_startframe_o (tx_startframe_o),
        .tx_endframe_o   (tx_endframe_o),
        .tx_padbytes_o   (tx_padbytes_o),
        .tx_frame_size_o (tx_frame_size_o),
        .tx_rdy_i        (tx_rdy_i)
    );

endmodule

`default_nettype wire

// ==== testbench/echo_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "echo_defs.svh"

module echo_top_tb;

    // Beats offered over all tests, as an upper bound
    localparam int MAX_BEATS      = 1 + 44 + 10 * 9 + 12 * 9 + 40;
    localparam int TIMEOUT_CYCLES = MAX_BEATS * 4 + 2000;

    logic                        clk;
    logic                        rst;
    logic                        rx_val_i;
    logic [`MAC_INTERFACE_W-1:0] rx_data_i;
    logic                        rx_last_i;
    logic [`MAC_PADBYTES_W-1:0]  rx_padbytes_i;
    logic                        rx_rdy_o;
    logic                        tx_val_o;
    logic [`MAC_INTERFACE_W-1:0] tx_data_o;
    logic                        tx_startframe_o;
    logic                        tx_endframe_o;
    logic [`MAC_PADBYTES_W-1:0]  tx_padbytes_o;
    logic [`MTU_SIZE_W-1:0]      tx_frame_size_o;
    logic                        tx_rdy_i;

    // Expected tx beats in order
    logic [31:0] exp_data [$];
    logic        exp_start [$];
    logic        exp_end [$];
    int          exp_pad [$];
    int          exp_size [$];

    int   error_count;
    int   check_count;
    int   cycle_count;
    logic rdy_random;
    logic rdy_hold;

    echo_top UUT (
        .clk             (clk),
        .rst             (rst),
        .rx_val_i        (rx_val_i),
        .rx_data_i       (rx_data_i),
        .rx_last_i       (rx_last_i),
        .rx_padbytes_i   (rx_padbytes_i),
        .rx_rdy_o        (rx_rdy_o),
        .tx_val_o        (tx_val_o),
        .tx_data_o       (tx_data_o),
        .tx_startframe_o (tx_startframe_o),
        .tx_endframe_o   (tx_endframe_o),
        .tx_padbytes_o   (tx_padbytes_o),
        .tx_frame_size_o (tx_frame_size_o),
        .tx_rdy_i        (tx_rdy_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
        end
    endtask

    // Queues the echoed form of each beat, then offers the beat until accepted
    task automatic send_frame(input int nbeats, input int pad);
        logic [31:0] word;
        logic        last;
        for (int i = 0; i < nbeats; i++) begin
            word = $urandom;
            last = (i == nbeats - 1);
            exp_data.push_back((i == 0) ? {word[15:0], word[31:16]} : word);
            exp_start.push_back(i == 0);
            exp_end.push_back(last);
            exp_pad.push_back(last ? pad : 0);
            exp_size.push_back(nbeats * 4 - pad);
            @(negedge clk);
            rx_val_i      = 1'b1;
            rx_data_i     = word;
            rx_last_i     = last;
            rx_padbytes_i = last ? pad[1:0] : 2'd0;
            @(posedge clk);
            while (!rx_rdy_o) @(posedge clk);
        end
    endtask

    task automatic idle_rx();
        @(negedge clk);
        rx_val_i      = 1'b0;
        rx_last_i     = 1'b0;
        rx_padbytes_i = '0;
    endtask

    task automatic wait_drain();
        while (exp_data.size() != 0) @(posedge clk);
        // Extra cycles expose any duplicated beat
        repeat (20) @(posedge clk);
    endtask

    // Scoreboard on every tx transfer
    always @(posedge clk) begin
        if (!rst && tx_val_o && tx_rdy_i) begin
            if (exp_data.size() == 0) begin
                error_count++;
                $display("Unexpected beat on the tx stream at %0t with no beat pending", $time);
            end else begin
                check_value("tx_data_o", tx_data_o, exp_data.pop_front());
                check_value("tx_startframe_o", tx_startframe_o, exp_start[0]);
                check_value("tx_endframe_o", tx_endframe_o, exp_end.pop_front());
                check_value("tx_padbytes_o", tx_padbytes_o, exp_pad.pop_front());
                if (exp_start[0]) begin
                    check_value("tx_frame_size_o", tx_frame_size_o, exp_size[0]);
                end
                void'(exp_start.pop_front());
                void'(exp_size.pop_front());
            end
        end
    end

    always @(negedge clk) begin
        tx_rdy_i = rdy_random ? $urandom_range(1, 0) : rdy_hold;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped delivering beats", cycle_count);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic reset_defaults();
        @(negedge clk);
        check_value("tx_val_o", tx_val_o, 1'b0);
        check_value("rx_rdy_o", rx_rdy_o, 1'b1);
    endtask

    task automatic single_beat_frame();
        send_frame(1, 1);
        idle_rx();
        wait_drain();
    endtask

    task automatic multi_beat_frames();
        for (int n = 2; n <= 9; n++) begin
            send_frame(n, n % 4);
            idle_rx();
        end
        wait_drain();
    endtask

    task automatic back_to_back_frames();
        for (int f = 0; f < 10; f++) begin
            send_frame($urandom_range(9, 1), $urandom_range(3, 0));
        end
        idle_rx();
        wait_drain();
    endtask

    task automatic random_tx_backpressure();
        rdy_random = 1'b1;
        for (int f = 0; f < 12; f++) begin
            send_frame($urandom_range(9, 1), $urandom_range(3, 0));
        end
        idle_rx();
        wait_drain();
        rdy_random = 1'b0;
    endtask

    // 40 beats against a blocked tx side overrun queue and stage
    task automatic full_stall_recovery();
        logic saw_stall;
        logic sent_all;
        saw_stall = 1'b0;
        sent_all  = 1'b0;
        rdy_hold  = 1'b0;
        fork
            begin
                for (int f = 0; f < 8; f++) begin
                    send_frame(5, f % 4);
                end
                sent_all = 1'b1;
            end
            begin
                while (!saw_stall && !sent_all) begin
                    @(posedge clk);
                    if (rx_val_i && !rx_rdy_o) begin
                        saw_stall = 1'b1;
                    end
                end
                repeat (10) @(posedge clk);
                rdy_hold = 1'b1;
            end
        join
        idle_rx();
        wait_drain();
        check_value("rx_rdy_o stall seen", saw_stall, 1'b1);
    endtask

    initial begin
        void'($urandom(11631));
        error_count   = 0;
        check_count   = 0;
        cycle_count   = 0;
        rdy_random    = 1'b0;
        rdy_hold      = 1'b1;
        tx_rdy_i      = 1'b1;
        rst           = 1'b1;
        rx_val_i      = 1'b0;
        rx_data_i     = '0;
        rx_last_i     = 1'b0;
        rx_padbytes_i = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        reset_defaults();
        single_beat_frame();
        multi_beat_frames();
        back_to_back_frames();
        random_tx_backpressure();
        full_stall_recovery();

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== echo_top.f ====
+incdir+include
src/frame_pkg.sv
src/echo_pkg.sv
src/frame_stream_if.sv
src/startframe_convert.sv
src/packet_queue_controller.sv
src/echo_engine.sv
src/echo_top.sv
testbench/echo_top_tb.sv

// ==== Bender.yml ====
package:
  name: echo_top

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/frame_pkg.sv
      - src/echo_pkg.sv
      - src/frame_stream_if.sv
      - src/startframe_convert.sv
      - src/packet_queue_controller.sv
      - src/echo_engine.sv
      - src/echo_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/echo_top_tb.sv
